// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f project.f --top-module tb_top -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
+incdir+src
src/mem_read_pkg.sv
src/icache_miss_req_buffer.sv
src/icache_refill_upsizer.sv
src/mem_read_arbiter.sv
src/mem_read_resp_demux.sv
src/cache_mem_read_arbiter.sv
test/tb_mem_model.sv
test/tb_top.sv

// File: src/cache_mem_read_arbiter.sv
/*
 * Read side of the cache memory arbiter: instruction cache, data cache miss
 * and uncached reads share one memory read port. No write path.
 * Response ids for the instruction cache and uncached reads must differ.
 */
module cache_mem_read_arbiter (
  input  logic                       clk_i,
  input  logic                       reset_i,

  // Instruction cache
  input  logic                       icache_miss_valid_i,
  output logic                       icache_miss_ready_o,
  input  mem_read_pkg::icache_req_t  icache_miss_i,
  input  mem_read_pkg::mem_id_t      icache_miss_id_i,
  output logic                       icache_resp_valid_o,
  output mem_read_pkg::icache_rtrn_t icache_resp_o,

  // Data cache miss path
  input  logic                       dcache_miss_valid_i,
  output logic                       dcache_miss_ready_o,
  input  mem_read_pkg::mem_req_t     dcache_miss_i,
  output logic                       dcache_miss_resp_valid_o,
  input  logic                       dcache_miss_resp_ready_i,
  output mem_read_pkg::mem_resp_t    dcache_miss_resp_o,

  // Uncached reads
  input  logic                       uc_read_valid_i,
  output logic                       uc_read_ready_o,
  input  mem_read_pkg::mem_req_t     uc_read_i,
  input  mem_read_pkg::mem_id_t      uc_read_id_i,
  output logic                       uc_read_resp_valid_o,
  input  logic                       uc_read_resp_ready_i,
  output mem_read_pkg::mem_resp_t    uc_read_resp_o,

  // Memory port
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output mem_read_pkg::mem_req_t     mem_req_o,
  input  logic                       mem_resp_valid_i,
  output logic                       mem_resp_ready_o,
  input  mem_read_pkg::mem_resp_t    mem_resp_i
);

  logic                             ic_req_valid;
  logic                             ic_req_ready;
  mem_read_pkg::mem_req_t           ic_req;
  logic [2:0]                       arb_ready;
  logic [2:0]                       resp_valid;
  logic [2:0]                       resp_ready;
  mem_read_pkg::mem_resp_t          resp;
  logic                             ic_beat_ready;

  icache_miss_req_buffer i_icache_req_buf (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (icache_miss_valid_i),
    .req_i       (icache_miss_i),
    .req_ready_o (icache_miss_ready_o),
    .out_valid_o (ic_req_valid),
    .out_o       (ic_req),
    .out_ready_i (ic_req_ready)
  );

  // Input 0 instruction cache, 1 miss path, 2 uncached
  mem_read_arbiter #(
    .N (3)
  ) i_read_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i ({uc_read_valid_i, dcache_miss_valid_i, ic_req_valid}),
    .req_i       ({uc_read_i, dcache_miss_i, ic_req}),
    .req_ready_o (arb_ready),
    .mem_valid_o (mem_req_valid_o),
    .mem_o       (mem_req_o),
    .mem_ready_i (mem_req_ready_i)
  );

  assign ic_req_ready        = arb_ready[0];
  assign dcache_miss_ready_o = arb_ready[1];
  assign uc_read_ready_o     = arb_ready[2];

  mem_read_resp_demux i_resp_demux (
    .resp_valid_i (mem_resp_valid_i),
    .resp_i       (mem_resp_i),
    .resp_ready_o (mem_resp_ready_o),
    .icache_id_i  (icache_miss_id_i),
    .uc_read_id_i (uc_read_id_i),
    .out_valid_o  (resp_valid),
    .out_ready_i  (resp_ready),
    .out_o        (resp)
  );

  assign resp_ready = {uc_read_resp_ready_i, dcache_miss_resp_ready_i, ic_beat_ready};

  assign dcache_miss_resp_valid_o = resp_valid[1];
  assign dcache_miss_resp_o       = resp;
  assign uc_read_resp_valid_o     = resp_valid[2];
  assign uc_read_resp_o           = resp;

  icache_refill_upsizer i_icache_upsizer (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .beat_valid_i (resp_valid[0]),
    .beat_i       (resp),
    .beat_ready_o (ic_beat_ready),
    .line_valid_o (icache_resp_valid_o),
    .line_o       (icache_resp_o)
  );

endmodule

// File: src/icache_miss_req_buffer.sv
/*
 * One-entry buffer between the instruction cache and the read arbiter.
 * Ready is "buffer empty", so a new request waits for the arbiter to drain it.
 * Cacheable fetches ask for a full line, non-cacheable ones for one 64-bit word.
 */
`include "mem_read_consts.svh"

module icache_miss_req_buffer (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_valid_i,
  input  mem_read_pkg::icache_req_t req_i,
  output logic                     req_ready_o,
  output logic                     out_valid_o,
  output mem_read_pkg::mem_req_t    out_o,
  input  logic                     out_ready_i
);

  logic                   full_q;
  logic                   push;
  logic                   pop;
  mem_read_pkg::mem_req_t req_d;
  mem_read_pkg::mem_req_t req_q;

  // Convert to the memory request format before it is stored
  always_comb begin
    req_d.addr      = req_i.paddr;
    req_d.id        = req_i.tid;
    req_d.cacheable = ~req_i.nc;
    req_d.size      = mem_read_pkg::mem_size_t'(`MEM_WORD_SIZE);
    if (req_i.nc) begin
      req_d.len = '0;
    end else begin
      req_d.len = mem_read_pkg::mem_len_t'(`ICACHE_LINE_BEATS - 1);
    end
  end

  assign push = req_valid_i & ~full_q;
  assign pop  = full_q & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (pop) begin
      full_q <= 1'b0;
    end
  end

  // Request payload, only loaded when the entry is free
  always_ff @(posedge clk_i) begin
    if (push) begin
      req_q <= req_d;
    end
  end

  assign req_ready_o = ~full_q;
  assign out_valid_o = full_q;
  assign out_o       = req_q;

endmodule

// File: src/icache_refill_upsizer.sv
/*
 * Packs 64-bit refill beats into a 128-bit instruction cache line, low half first.
 * The line is shown for one cycle after the last beat and no beat is taken then.
 * A single-beat refill leaves the upper beats zero.
 */
`include "mem_read_consts.svh"

module icache_refill_upsizer (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       beat_valid_i,
  input  mem_read_pkg::mem_resp_t    beat_i,
  output logic                       beat_ready_o,
  output logic                       line_valid_o,
  output mem_read_pkg::icache_rtrn_t line_o
);

  localparam int CNT_W = $clog2(`ICACHE_LINE_BEATS);

  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [`ICACHE_LINE_BEATS-1:0][`MEM_DATA_W-1:0] line_beats_t;

  mem_read_pkg::upsize_state_e state_q;
  cnt_t                        cnt_q;
  logic                        beat_fire;
  line_beats_t                 line_d;
  line_beats_t                 line_q;
  mem_read_pkg::mem_id_t       tid_q;

  assign beat_ready_o = (state_q == mem_read_pkg::FILL);
  assign beat_fire    = beat_valid_i & beat_ready_o;

  // First beat of a line clears the rest
  always_comb begin
    line_d        = (cnt_q == '0) ? '0 : line_q;
    line_d[cnt_q] = beat_i.data;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= mem_read_pkg::FILL;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        mem_read_pkg::FILL: begin
          if (beat_fire) begin
            if (beat_i.last) begin
              state_q <= mem_read_pkg::FULL;
              cnt_q   <= '0;
            end else begin
              cnt_q <= cnt_q + cnt_t'(1);
            end
          end
        end
        default: state_q <= mem_read_pkg::FILL;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      line_q <= line_d;
      if (beat_i.last) begin
        tid_q <= beat_i.id;
      end
    end
  end

  assign line_valid_o = (state_q == mem_read_pkg::FULL);
  assign line_o.data  = line_q;
  assign line_o.tid   = tid_q;

endmodule

// File: src/mem_read_arbiter.sv
/*
 * Round-robin arbiter for read requests, combinational from request to port.
 * A grant stalled by the memory is held until it transfers, so requesters
 * must keep valid and the request steady once offered.
 */
module mem_read_arbiter #(
  parameter int N = 3
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [N-1:0]                   req_valid_i,
  input  mem_read_pkg::mem_req_t [N-1:0] req_i,
  output logic [N-1:0]                   req_ready_o,
  output logic                           mem_valid_o,
  output mem_read_pkg::mem_req_t         mem_o,
  input  logic                           mem_ready_i
);

  localparam int IDX_W = $clog2(N);

  typedef logic [IDX_W-1:0] idx_t;

  idx_t ptr_q;
  idx_t grant_q;
  logic lock_q;
  idx_t pick;
  logic found;
  idx_t grant;
  logic xfer;

  // First valid input at or after the pointer
  always_comb begin
    pick  = ptr_q;
    found = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (!found && req_valid_i[(int'(ptr_q) + i) % N]) begin
        pick  = idx_t'((int'(ptr_q) + i) % N);
        found = 1'b1;
      end
    end
  end

  assign grant       = lock_q ? grant_q : pick;
  assign mem_valid_o = req_valid_i[grant];
  assign mem_o       = req_i[grant];
  assign xfer        = mem_valid_o & mem_ready_i;

  always_comb begin
    req_ready_o = '0;
    req_ready_o[grant] = xfer;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q   <= '0;
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else if (xfer) begin
      lock_q <= 1'b0;
      ptr_q  <= (int'(grant) == N - 1) ? '0 : grant + idx_t'(1);
    end else if (mem_valid_o) begin
      // Stalled by memory, keep this grant
      lock_q  <= 1'b1;
      grant_q <= grant;
    end
  end

endmodule

// File: src/mem_read_consts.svh
/*
 * Widths and request sizes for the memory read path.
 * A line must be a whole number of beats. Non-cacheable fetches are one beat.
 */
`ifndef MEM_READ_CONSTS_SVH
`define MEM_READ_CONSTS_SVH

// Memory port
`define MEM_DATA_W 64
`define MEM_ADDR_W 32
`define MEM_ID_W 2
`define MEM_LEN_W 8
`define MEM_SIZE_W 3

// Instruction cache line
`define ICACHE_LINE_W 128
`define ICACHE_LINE_BEATS 2

// log2 of bytes per beat, both fetch kinds
`define MEM_WORD_SIZE 3

`endif

// File: src/mem_read_pkg.sv
/*
 * Types shared by the read arbiter blocks.
 * Field order in the structs is part of the memory port format.
 */
`include "mem_read_consts.svh"

package mem_read_pkg;

  typedef logic [`MEM_ADDR_W-1:0]    mem_addr_t;
  typedef logic [`MEM_ID_W-1:0]      mem_id_t;
  typedef logic [`MEM_DATA_W-1:0]    mem_data_t;
  typedef logic [`ICACHE_LINE_W-1:0] icache_line_t;

  // Number of beats minus one
  typedef logic [`MEM_LEN_W-1:0]  mem_len_t;
  typedef logic [`MEM_SIZE_W-1:0] mem_size_t;

  // Read request on the shared memory port
  typedef struct packed {
    mem_addr_t addr;
    mem_len_t  len;
    mem_size_t size;
    mem_id_t   id;
    logic      cacheable;
  } mem_req_t;

  // One response beat
  typedef struct packed {
    mem_id_t   id;
    mem_data_t data;
    logic      last;
    logic      error;
  } mem_resp_t;

  // Instruction cache miss request
  typedef struct packed {
    mem_addr_t paddr;
    logic      nc;
    mem_id_t   tid;
  } icache_req_t;

  // Instruction cache refill
  typedef struct packed {
    icache_line_t data;
    mem_id_t      tid;
  } icache_rtrn_t;

  typedef enum logic {
    FILL,
    FULL
  } upsize_state_e;

endpackage

// File: src/mem_read_resp_demux.sv
/*
 * Steers read responses by transaction id, purely combinational.
 * Instruction cache id wins over the uncached id if both are equal.
 * Any other id goes to the data cache miss path.
 */
module mem_read_resp_demux (
  input  logic                    resp_valid_i,
  input  mem_read_pkg::mem_resp_t resp_i,
  output logic                    resp_ready_o,
  input  mem_read_pkg::mem_id_t   icache_id_i,
  input  mem_read_pkg::mem_id_t   uc_read_id_i,
  output logic [2:0]              out_valid_o,
  input  logic [2:0]              out_ready_i,
  output mem_read_pkg::mem_resp_t out_o
);

  localparam int unsigned DST_ICACHE = 0;
  localparam int unsigned DST_MISS   = 1;
  localparam int unsigned DST_UC     = 2;

  logic [1:0] sel;

  // Destination decode
  always_comb begin
    if (resp_i.id == icache_id_i) begin
      sel = 2'(DST_ICACHE);
    end else if (resp_i.id == uc_read_id_i) begin
      sel = 2'(DST_UC);
    end else begin
      sel = 2'(DST_MISS);
    end
  end

  always_comb begin
    out_valid_o      = '0;
    out_valid_o[sel] = resp_valid_i;
  end

  // Only the selected destination can stall the memory
  assign resp_ready_o = out_ready_i[sel];
  assign out_o        = resp_i;

endmodule

// File: test/tb_mem_model.sv
/*
 * Memory model for the read port. Responses come back in request order,
 * after a random gap, one beat per cycle while ready is high.
 */
module tb_mem_model (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mem_read_pkg::mem_req_t  req_i,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output mem_read_pkg::mem_resp_t resp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  mem_read_pkg::mem_req_t  pend[$];
  logic                    req_ready_q = 1'b0;
  logic                    resp_valid_q = 1'b0;
  mem_read_pkg::mem_resp_t resp_q = '0;
  int                      beat_idx = 0;
  int                      gap = 0;

  assign req_ready_o  = req_ready_q;
  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

  // Beat k of the line at addr, spread over the whole address
  function automatic mem_read_pkg::mem_resp_t beat_for(mem_read_pkg::mem_req_t req, int k);
    mem_read_pkg::mem_resp_t r;
    r.id    = req.id;
    r.data  = {req.addr ^ 32'ha5a5_0000, req.addr + 32'(k) * 32'd8};
    r.last  = (k == int'(req.len));
    r.error = 1'b0;
    return r;
  endfunction

  always @(posedge clk_i) begin
    if (reset_i) begin
      req_ready_q  <= 1'b0;
      resp_valid_q <= 1'b0;
      beat_idx = 0;
      gap = 0;
      pend.delete();
    end else begin
      if (req_valid_i && req_ready_q) begin
        pend.push_back(req_i);
      end
      req_ready_q <= ($urandom_range(3) != 0);
      if (resp_valid_q && resp_ready_i) begin
        if (beat_idx == int'(pend[0].len)) begin
          void'(pend.pop_front());
          beat_idx = 0;
          gap = $urandom_range(5);
          resp_valid_q <= 1'b0;
        end else begin
          beat_idx++;
          resp_q <= beat_for(pend[0], beat_idx);
        end
      end else if (!resp_valid_q) begin
        if (gap > 0) begin
          gap--;
        end else if (pend.size() > 0) begin
          resp_valid_q <= 1'b1;
          resp_q       <= beat_for(pend[0], 0);
        end
      end
    end
  end

endmodule

// File: test/tb_top.sv
/*
 * Testbench for the read arbiter. Ids are fixed: instruction cache 0,
 * uncached reads 2, misses 1 and 3. Outputs are sampled on the falling edge.
 */
`include "mem_read_consts.svh"

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_REQ = 64;

  logic clk_i = 1'b0;
  logic reset_i;
  logic icache_miss_valid_i = 1'b0;
  logic dcache_miss_valid_i = 1'b0;
  logic uc_read_valid_i = 1'b0;
  logic dcache_miss_resp_ready_i = 1'b1;
  logic uc_read_resp_ready_i = 1'b1;
  logic icache_miss_ready_o, icache_resp_valid_o, dcache_miss_ready_o;
  logic dcache_miss_resp_valid_o, uc_read_ready_o, uc_read_resp_valid_o;
  logic mem_req_valid_o, mem_req_ready_i, mem_resp_valid_i, mem_resp_ready_o;
  mem_read_pkg::icache_req_t  icache_miss_i = '0;
  mem_read_pkg::mem_req_t     dcache_miss_i = '0;
  mem_read_pkg::mem_req_t     uc_read_i = '0;
  mem_read_pkg::mem_id_t      icache_miss_id_i;
  mem_read_pkg::mem_id_t      uc_read_id_i;
  mem_read_pkg::icache_rtrn_t icache_resp_o;
  mem_read_pkg::mem_resp_t    dcache_miss_resp_o, uc_read_resp_o, mem_resp_i;
  mem_read_pkg::mem_req_t     mem_req_o;

  // Source queues, expected requests and responses, and the grant log
  mem_read_pkg::icache_req_t  ic_src[$];
  mem_read_pkg::mem_req_t     miss_src[$];
  mem_read_pkg::mem_req_t     uc_src[$];
  mem_read_pkg::icache_req_t  ic_req_q[$];
  mem_read_pkg::mem_req_t     miss_req_q[$];
  mem_read_pkg::mem_req_t     uc_req_q[$];
  mem_read_pkg::icache_rtrn_t exp_line[$];
  mem_read_pkg::mem_resp_t    exp_miss[$];
  mem_read_pkg::mem_resp_t    exp_uc[$];
  int                         grants[$];
  logic ic_rdy = 1'b0;
  logic miss_rdy = 1'b0;
  logic uc_rdy = 1'b0;
  bit   resp_rand = 1'b0;
  bit   miss_hold = 1'b0;
  int   errors = 0;
  int   tests = 0;

  always #20 clk_i = ~clk_i;

  cache_mem_read_arbiter DUT (.*);

  tb_mem_model i_mem (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (mem_req_valid_o),
    .req_ready_o  (mem_req_ready_i),
    .req_i        (mem_req_o),
    .resp_valid_o (mem_resp_valid_i),
    .resp_ready_i (mem_resp_ready_o),
    .resp_o       (mem_resp_i)
  );

  function automatic mem_read_pkg::mem_data_t beat_data(mem_read_pkg::mem_addr_t addr, int k);
    return {addr ^ 32'ha5a5_0000, addr + 32'(k) * 32'd8};
  endfunction

  // Sources hold valid until the sampled ready shows a transfer
  always @(posedge clk_i) begin
    if (icache_miss_valid_i && ic_rdy) void'(ic_src.pop_front());
    if (dcache_miss_valid_i && miss_rdy) void'(miss_src.pop_front());
    if (uc_read_valid_i && uc_rdy) void'(uc_src.pop_front());
    icache_miss_valid_i <= !reset_i && ic_src.size() > 0;
    dcache_miss_valid_i <= !reset_i && miss_src.size() > 0;
    uc_read_valid_i     <= !reset_i && uc_src.size() > 0;
    if (ic_src.size() > 0) icache_miss_i <= ic_src[0];
    if (miss_src.size() > 0) dcache_miss_i <= miss_src[0];
    if (uc_src.size() > 0) uc_read_i <= uc_src[0];
    dcache_miss_resp_ready_i <= miss_hold ? 1'b0 : (resp_rand ? 1'($urandom_range(1)) : 1'b1);
    uc_read_resp_ready_i     <= resp_rand ? 1'($urandom_range(1)) : 1'b1;
  end

  task automatic check_val(string name, logic [`ICACHE_LINE_W+`MEM_ID_W-1:0] got,
                           logic [`ICACHE_LINE_W+`MEM_ID_W-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Each request on the memory port is matched in order against what its
  // source issued, and the responses it should produce are queued
  task automatic record_req(mem_read_pkg::mem_req_t r);
    mem_read_pkg::icache_req_t  ic;
    mem_read_pkg::mem_req_t     src;
    mem_read_pkg::icache_rtrn_t line;
    mem_read_pkg::mem_resp_t    b;
    bit                         found;
    grants.push_back((r.id == 2'd0) ? 0 : ((r.id == 2'd2) ? 2 : 1));
    if (r.id == 2'd0) begin
      if (ic_req_q.size() == 0) begin
        $display("Instruction cache request on the memory port that was never issued");
        errors++;
      end else begin
        ic = ic_req_q.pop_front();
        check_val("mem_req_o.addr", r.addr, ic.paddr);
        check_val("mem_req_o.id", r.id, ic.tid);
        check_val("mem_req_o.len", r.len, ic.nc ? 0 : `ICACHE_LINE_BEATS - 1);
        check_val("mem_req_o.size", r.size, `MEM_WORD_SIZE);
        check_val("mem_req_o.cacheable", r.cacheable, !ic.nc);
        line = '0;
        line.tid = ic.tid;
        for (int k = 0; k < (ic.nc ? 1 : `ICACHE_LINE_BEATS); k++) begin
          line.data[k*`MEM_DATA_W +: `MEM_DATA_W] = beat_data(ic.paddr, k);
        end
        exp_line.push_back(line);
      end
    end else begin
      found = 1'b0;
      if (r.id == 2'd2 && uc_req_q.size() > 0) begin
        src   = uc_req_q.pop_front();
        found = 1'b1;
      end else if (r.id != 2'd2 && miss_req_q.size() > 0) begin
        src   = miss_req_q.pop_front();
        found = 1'b1;
      end
      if (!found) begin
        $display("Data cache request on the memory port that was never issued");
        errors++;
      end else begin
        check_val("mem_req_o", r, src);
        for (int k = 0; k <= int'(src.len); k++) begin
          b.id    = src.id;
          b.data  = beat_data(src.addr, k);
          b.last  = (k == int'(src.len));
          b.error = 1'b0;
          if (src.id == 2'd2) exp_uc.push_back(b);
          else exp_miss.push_back(b);
        end
      end
    end
  endtask

  task automatic check_resp(string name, mem_read_pkg::mem_resp_t got,
                            ref mem_read_pkg::mem_resp_t exp_q[$]);
    if (exp_q.size() == 0) begin
      $display("Unexpected response on %s with nothing outstanding", name);
      errors++;
    end else begin
      check_val(name, got, exp_q.pop_front());
    end
  endtask

  // Compare process
  always @(negedge clk_i) begin
    ic_rdy   = icache_miss_ready_o;
    miss_rdy = dcache_miss_ready_o;
    uc_rdy   = uc_read_ready_o;
    if (!reset_i) begin
      if (mem_req_valid_o && mem_req_ready_i) record_req(mem_req_o);
      if (icache_resp_valid_o) begin
        if (exp_line.size() == 0) begin
          $display("Unexpected instruction cache line with nothing outstanding");
          errors++;
        end else begin
          check_val("icache_resp_o", icache_resp_o, exp_line.pop_front());
        end
      end
      if (dcache_miss_resp_valid_o && dcache_miss_resp_ready_i)
        check_resp("dcache_miss_resp_o", dcache_miss_resp_o, exp_miss);
      if (uc_read_resp_valid_o && uc_read_resp_ready_i)
        check_resp("uc_read_resp_o", uc_read_resp_o, exp_uc);
      if (dcache_miss_resp_valid_o && !dcache_miss_resp_ready_i)
        check_val("mem_resp_ready_o", mem_resp_ready_o, 1'b0);
    end
  end

  task automatic push_ic(bit nc);
    mem_read_pkg::icache_req_t r;
    r.paddr = {12'h0, 16'($urandom_range(16'hffff)), 4'h0};
    r.nc    = nc;
    r.tid   = 2'd0;
    ic_req_q.push_back(r);
    ic_src.push_back(r);
  endtask

  task automatic push_dc(bit uc);
    mem_read_pkg::mem_req_t r;
    r.addr      = {12'h0, 16'($urandom_range(16'hffff)), 4'h0};
    r.len       = uc ? 8'd0 : 8'd1;
    r.size      = `MEM_WORD_SIZE;
    r.id        = uc ? 2'd2 : ($urandom_range(1) ? 2'd3 : 2'd1);
    r.cacheable = !uc;
    if (uc) begin
      uc_req_q.push_back(r);
      uc_src.push_back(r);
    end else begin
      miss_req_q.push_back(r);
      miss_src.push_back(r);
    end
  endtask

  task automatic finish_test(string name, int err0);
    do @(negedge clk_i);
    while (ic_src.size() + miss_src.size() + uc_src.size() + ic_req_q.size() +
           miss_req_q.size() + uc_req_q.size() + exp_line.size() +
           exp_miss.size() + exp_uc.size() > 0 || mem_req_valid_o || mem_resp_valid_i);
    repeat (4) @(negedge clk_i);
    tests++;
    $display("Test %s: %0d errors", name, errors - err0);
  endtask

  initial begin
    int err0;
    int cnt[3];
    void'($urandom(51287));
    reset_i = 1'b1;
    icache_miss_id_i = 2'd0;
    uc_read_id_i = 2'd2;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    err0 = errors;
    push_ic(1'b0);
    push_ic(1'b0);
    finish_test("cacheable fetch", err0);

    err0 = errors;
    push_ic(1'b1);
    push_ic(1'b1);
    finish_test("non-cacheable fetch", err0);

    err0 = errors;
    for (int i = 0; i < 8; i++) push_dc(i[0]);
    finish_test("routing by id", err0);

    err0 = errors;
    grants.delete();
    for (int i = 0; i < 6; i++) begin
      push_ic(1'b0);
      push_dc(1'b0);
      push_dc(1'b1);
    end
    finish_test_fair: begin
      finish_test("round-robin", err0);
      cnt = '{0, 0, 0};
      foreach (grants[i]) begin
        cnt[grants[i]]++;
        if (i > 0 && grants[i] == grants[i-1]) begin
          $display("Requester %0d was granted twice in a row", grants[i]);
          errors++;
        end
      end
      // Each share within one of a third
      foreach (cnt[j]) begin
        if (3 * cnt[j] > grants.size() + 3 || 3 * cnt[j] < grants.size() - 3) begin
          $display("Requester %0d got %0d of %0d grants", j, cnt[j], grants.size());
          errors++;
        end
      end
    end

    err0 = errors;
    @(posedge clk_i);
    miss_hold <= 1'b1;
    for (int i = 0; i < 3; i++) push_dc(1'b0);
    do @(negedge clk_i);
    while (!dcache_miss_resp_valid_o);
    repeat (20) @(posedge clk_i);
    miss_hold <= 1'b0;
    finish_test("back-pressure", err0);

    err0 = errors;
    resp_rand = 1'b1;
    for (int i = 0; i < 31; i++) begin
      case ($urandom_range(2))
        0: push_ic(1'($urandom_range(1)));
        1: push_dc(1'b0);
        default: push_dc(1'b1);
      endcase
    end
    finish_test("overlap", err0);

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the reset time and the number of requests
  initial begin
    #((8 + 200 * N_REQ) * 40);
    $display("Timeout: the tests did not complete in time");
    $display("Regression failed");
    $finish;
  end

endmodule
